/* source/spi_engine_regs_pkg.sv */
`default_nettype none

package spi_engine_regs_pkg;

	// ******************************************************************
	// Register map, word addresses
	// ******************************************************************

	typedef logic [7:0] reg_addr_t;

	localparam reg_addr_t addr_version = 8'h00;
	localparam reg_addr_t addr_id = 8'h01;
	localparam reg_addr_t addr_scratch = 8'h02;
	localparam reg_addr_t addr_reset = 8'h10;
	localparam reg_addr_t addr_irq_mask = 8'h20;
	localparam reg_addr_t addr_irq_pending = 8'h21;
	localparam reg_addr_t addr_irq_source = 8'h22;
	localparam reg_addr_t addr_sync_id = 8'h30;
	localparam reg_addr_t addr_cmd_room = 8'h34;
	localparam reg_addr_t addr_sdo_room = 8'h35;
	localparam reg_addr_t addr_sdi_level = 8'h36;
	localparam reg_addr_t addr_cmd_fifo = 8'h38;
	localparam reg_addr_t addr_sdo_fifo = 8'h39;
	localparam reg_addr_t addr_sdi_fifo = 8'h3a;
	localparam reg_addr_t addr_sdi_peek = 8'h3c;	// Head of SDI FIFO, no pop
	localparam reg_addr_t addr_offload_enable = 8'h40;
	localparam reg_addr_t addr_offload_enabled = 8'h41;
	localparam reg_addr_t addr_offload_mem_reset = 8'h42;
	localparam reg_addr_t addr_offload_cmd = 8'h44;
	localparam reg_addr_t addr_offload_sdo = 8'h45;

	localparam logic [31:0] core_version = 32'h0001_0071;

	// Bit positions in mask, pending and source
	typedef enum logic [1:0] {
		irq_cmd_almost_empty = 2'd0,
		irq_sdo_almost_empty = 2'd1,
		irq_sdi_almost_full = 2'd2,
		irq_sync = 2'd3
	} irq_bit_e;

endpackage

`default_nettype wire

/* source/spi_engine_stream_pkg.sv */
`default_nettype none

package spi_engine_stream_pkg;

	// ******************************************************************
	// Internal register bus
	// ******************************************************************

	typedef struct packed {
		spi_engine_regs_pkg::reg_addr_t addr;
		logic [31:0] data;
		logic strobe;	// One cycle per request
	} up_req_t;

	typedef struct packed {
		logic ack;
		logic [31:0] data;
	} up_resp_t;

	// ******************************************************************
	// Engine stream words
	// ******************************************************************

	typedef logic [15:0] cmd_word_t;
	typedef logic [7:0] sdo_word_t;

endpackage

`default_nettype wire

/* source/axi_lite_slave.sv */
`default_nettype none
`timescale 1ns/1ps

module axi_lite_slave import spi_engine_regs_pkg::*, spi_engine_stream_pkg::*; (
	input logic s_axi_aclk,
	input logic s_axi_aresetn,

	input logic awvalid,
	input logic [31:0] awaddr,
	input logic [2:0] awprot,	// Ignored
	output logic awready,
	input logic wvalid,
	input logic [31:0] wdata,
	input logic [3:0] wstrb,	// Ignored, full words only
	output logic wready,
	output logic bvalid,
	output logic [1:0] bresp,
	input logic bready,
	input logic arvalid,
	input logic [31:0] araddr,
	input logic [2:0] arprot,	// Ignored
	output logic arready,
	output logic rvalid,
	output logic [1:0] rresp,
	output logic [31:0] rdata,
	input logic rready,

	output up_req_t wr_req,
	input logic wr_ack,
	output up_req_t rd_req,
	input up_resp_t rd_resp
);

	localparam int addr_msb = $bits(reg_addr_t) + 1;
	localparam logic [1:0] resp_okay = 2'b00;

	logic wr_busy;
	logic rd_busy;
	logic wr_accept;
	logic rd_accept;

	// ******************************************************************
	// Write channel, one transaction outstanding
	// ******************************************************************

	assign wr_accept = awvalid && wvalid && !wr_busy;
	assign awready = wr_accept;
	assign wready = wr_accept;
	assign bresp = resp_okay;

	assign wr_req.addr = awaddr[addr_msb:2];	// Byte to word address
	assign wr_req.data = wdata;
	assign wr_req.strobe = wr_accept;

	always_ff @(posedge s_axi_aclk) begin
		if (!s_axi_aresetn) begin
			wr_busy <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			if (wr_accept)
				wr_busy <= 1'b1;
			else if (bvalid && bready)
				wr_busy <= 1'b0;

			if (wr_ack)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
		end
	end

	// ******************************************************************
	// Read channel
	// ******************************************************************

	assign rd_accept = arvalid && !rd_busy;
	assign arready = rd_accept;
	assign rresp = resp_okay;

	assign rd_req.addr = araddr[addr_msb:2];
	assign rd_req.data = '0;
	assign rd_req.strobe = rd_accept;

	always_ff @(posedge s_axi_aclk) begin
		if (!s_axi_aresetn) begin
			rd_busy <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			if (rd_accept)
				rd_busy <= 1'b1;
			else if (rvalid && rready)
				rd_busy <= 1'b0;

			if (rd_resp.ack)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	// Data stays put until the next acknowledge
	always_ff @(posedge s_axi_aclk) begin
		if (rd_resp.ack)
			rdata <= rd_resp.data;
	end

endmodule

`default_nettype wire

/* source/spi_engine_fifo.sv */
`default_nettype none
`timescale 1ns/1ps

module spi_engine_fifo #(
	parameter int data_width = 8,
	parameter int address_width = 4
) (
	input logic s_axi_aclk,
	input logic resetn,

	input logic in_valid,
	input logic [data_width-1:0] in_data,
	output logic in_ready,

	input logic out_ready,
	output logic out_valid,
	output logic [data_width-1:0] out_data,

	output logic [address_width:0] level,
	output logic [address_width:0] room
);

	localparam int depth = 2 ** address_width;
	localparam logic [address_width:0] full_count = (address_width + 1)'(depth);

	logic [data_width-1:0] mem [depth];
	logic [address_width-1:0] wr_ptr;
	logic [address_width-1:0] rd_ptr;
	logic [address_width:0] count;
	logic push;
	logic pop;

	assign in_ready = count != full_count;	// Push into a full FIFO is dropped
	assign out_valid = count != '0;
	assign push = in_valid && in_ready;
	assign pop = out_valid && out_ready;

	assign out_data = mem[rd_ptr];	// First word falls through
	assign level = count;
	assign room = full_count - count;

	always_ff @(posedge s_axi_aclk) begin
		if (push)
			mem[wr_ptr] <= in_data;
	end

	// Pointers wrap on their own, depth is a power of two
	always_ff @(posedge s_axi_aclk) begin
		if (!resetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;

			case ({push, pop})
			2'b10: count <= count + 1'b1;
			2'b01: count <= count - 1'b1;
			default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/spi_engine_regs.sv */
`default_nettype none
`timescale 1ns/1ps

module spi_engine_regs import spi_engine_regs_pkg::*, spi_engine_stream_pkg::*; #(
	parameter int cmd_fifo_address_width = 4,
	parameter int sdo_fifo_address_width = 5,
	parameter int sdi_fifo_address_width = 5,
	parameter int sdi_data_width = 8,
	parameter logic [31:0] id = 32'h0
) (
	input logic s_axi_aclk,
	input logic s_axi_aresetn,

	input up_req_t wr_req,
	input up_req_t rd_req,
	output logic wr_ack,
	output up_resp_t rd_resp,

	output logic cmd_push,
	output cmd_word_t cmd_push_data,
	input logic [cmd_fifo_address_width:0] cmd_room,

	output logic sdo_push,
	output sdo_word_t sdo_push_data,
	input logic [sdo_fifo_address_width:0] sdo_room,

	output logic sdi_pop,
	input logic [sdi_data_width-1:0] sdi_head,
	input logic [sdi_fifo_address_width:0] sdi_level,

	output logic fifo_resetn,

	output logic sync_ready,
	input logic sync_valid,
	input logic [7:0] sync_data,

	output logic irq,

	output logic offload_cmd_wr_en,
	output cmd_word_t offload_cmd_wr_data,
	output logic offload_sdo_wr_en,
	output sdo_word_t offload_sdo_wr_data,
	output logic offload_mem_reset,
	output logic offload_enable,
	input logic offload_enabled
);

	// Three quarters of each FIFO depth
	localparam logic [cmd_fifo_address_width:0] cmd_mark =
		(cmd_fifo_address_width + 1)'(3 << (cmd_fifo_address_width - 2));
	localparam logic [sdo_fifo_address_width:0] sdo_mark =
		(sdo_fifo_address_width + 1)'(3 << (sdo_fifo_address_width - 2));
	localparam logic [sdi_fifo_address_width:0] sdi_mark =
		(sdi_fifo_address_width + 1)'(3 << (sdi_fifo_address_width - 2));

	logic [31:0] scratch;
	logic soft_reset;
	logic [3:0] irq_mask;
	logic [3:0] irq_source;
	logic [3:0] irq_pending;
	logic [7:0] sync_id;
	logic sync_pending;
	logic rd_ack;
	logic [31:0] rd_data;
	logic [31:0] rd_data_q;

	// ******************************************************************
	// Write decode
	// ******************************************************************

	always_ff @(posedge s_axi_aclk) begin
		if (!s_axi_aresetn) begin
			wr_ack <= 1'b0;
			scratch <= '0;
			soft_reset <= 1'b1;	// Engine starts held in reset
			irq_mask <= '0;
			offload_enable <= 1'b0;
			offload_mem_reset <= 1'b0;
		end else begin
			wr_ack <= wr_req.strobe;
			offload_mem_reset <= 1'b0;
			if (wr_req.strobe) begin
				case (wr_req.addr)
				addr_scratch: scratch <= wr_req.data;
				addr_reset: soft_reset <= wr_req.data[0];
				addr_irq_mask: irq_mask <= wr_req.data[3:0];
				addr_offload_enable: offload_enable <= wr_req.data[0];
				addr_offload_mem_reset: offload_mem_reset <= wr_req.data[0];
				default: ;
				endcase
			end
		end
	end

	assign fifo_resetn = !soft_reset;

	assign cmd_push = wr_req.strobe && wr_req.addr == addr_cmd_fifo;
	assign cmd_push_data = wr_req.data[15:0];
	assign sdo_push = wr_req.strobe && wr_req.addr == addr_sdo_fifo;
	assign sdo_push_data = wr_req.data[7:0];

	assign offload_cmd_wr_en = wr_req.strobe && wr_req.addr == addr_offload_cmd;
	assign offload_cmd_wr_data = wr_req.data[15:0];
	assign offload_sdo_wr_en = wr_req.strobe && wr_req.addr == addr_offload_sdo;
	assign offload_sdo_wr_data = wr_req.data[7:0];

	// ******************************************************************
	// Sync capture and interrupt
	// ******************************************************************

	assign sync_ready = 1'b1;

	always_ff @(posedge s_axi_aclk) begin
		if (!s_axi_aresetn || !fifo_resetn) begin
			sync_id <= '0;
			sync_pending <= 1'b0;
		end else if (sync_valid) begin	// New event beats a clear
			sync_id <= sync_data;
			sync_pending <= 1'b1;
		end else if (wr_req.strobe && wr_req.addr == addr_irq_pending &&
				wr_req.data[irq_sync]) begin
			sync_pending <= 1'b0;
		end
	end

	always_comb begin
		irq_source = '0;
		irq_source[irq_cmd_almost_empty] = cmd_room >= cmd_mark;
		irq_source[irq_sdo_almost_empty] = sdo_room >= sdo_mark;
		irq_source[irq_sdi_almost_full] = sdi_level >= sdi_mark;
		irq_source[irq_sync] = sync_pending;
	end

	assign irq_pending = irq_mask & irq_source;

	always_ff @(posedge s_axi_aclk) begin
		if (!s_axi_aresetn)
			irq <= 1'b0;
		else
			irq <= |irq_pending;
	end

	// ******************************************************************
	// Readback
	// ******************************************************************

	assign sdi_pop = rd_req.strobe && rd_req.addr == addr_sdi_fifo;

	always_comb begin
		rd_data = '0;
		case (rd_req.addr)
		addr_version: rd_data = core_version;
		addr_id: rd_data = id;
		addr_scratch: rd_data = scratch;
		addr_reset: rd_data[0] = soft_reset;
		addr_irq_mask: rd_data[3:0] = irq_mask;
		addr_irq_pending: rd_data[3:0] = irq_pending;
		addr_irq_source: rd_data[3:0] = irq_source;
		addr_sync_id: rd_data[7:0] = sync_id;
		addr_cmd_room: rd_data[cmd_fifo_address_width:0] = cmd_room;
		addr_sdo_room: rd_data[sdo_fifo_address_width:0] = sdo_room;
		addr_sdi_level: rd_data[sdi_fifo_address_width:0] = sdi_level;
		addr_sdi_fifo, addr_sdi_peek: rd_data[sdi_data_width-1:0] = sdi_head;
		addr_offload_enable: rd_data[0] = offload_enable;
		addr_offload_enabled: rd_data[0] = offload_enabled;
		default: ;
		endcase
	end

	always_ff @(posedge s_axi_aclk) begin
		if (!s_axi_aresetn)
			rd_ack <= 1'b0;
		else
			rd_ack <= rd_req.strobe;
	end

	// Head is sampled before the pop lands
	always_ff @(posedge s_axi_aclk) begin
		if (rd_req.strobe)
			rd_data_q <= rd_data;
	end

	assign rd_resp.ack = rd_ack;
	assign rd_resp.data = rd_data_q;

endmodule

`default_nettype wire

/* source/axi_spi_engine.sv */
`default_nettype none
`timescale 1ns/1ps

module axi_spi_engine import spi_engine_stream_pkg::*; #(
	parameter int cmd_fifo_address_width = 4,
	parameter int sdo_fifo_address_width = 5,
	parameter int sdi_fifo_address_width = 5,
	parameter int sdi_data_width = 8,	// 8, 16, 24 or 32
	parameter logic [31:0] id = 32'h0
) (
	input logic s_axi_aclk,
	input logic s_axi_aresetn,

	input logic s_axi_awvalid,
	input logic [31:0] s_axi_awaddr,
	output logic s_axi_awready,
	input logic [2:0] s_axi_awprot,
	input logic s_axi_wvalid,
	input logic [31:0] s_axi_wdata,
	input logic [3:0] s_axi_wstrb,
	output logic s_axi_wready,
	output logic s_axi_bvalid,
	output logic [1:0] s_axi_bresp,
	input logic s_axi_bready,
	input logic s_axi_arvalid,
	input logic [31:0] s_axi_araddr,
	output logic s_axi_arready,
	input logic [2:0] s_axi_arprot,
	output logic s_axi_rvalid,
	input logic s_axi_rready,
	output logic [1:0] s_axi_rresp,
	output logic [31:0] s_axi_rdata,

	output logic irq,
	output logic spi_resetn,

	input logic cmd_ready,
	output logic cmd_valid,
	output cmd_word_t cmd_data,

	input logic sdo_data_ready,
	output logic sdo_data_valid,
	output sdo_word_t sdo_data,

	output logic sdi_data_ready,
	input logic sdi_data_valid,
	input logic [sdi_data_width-1:0] sdi_data,

	output logic sync_ready,
	input logic sync_valid,
	input logic [7:0] sync_data,

	output logic offload0_cmd_wr_en,
	output cmd_word_t offload0_cmd_wr_data,
	output logic offload0_sdo_wr_en,
	output sdo_word_t offload0_sdo_wr_data,
	output logic offload0_mem_reset,
	output logic offload0_enable,
	input logic offload0_enabled
);

	up_req_t wr_req;
	up_req_t rd_req;
	logic wr_ack;
	up_resp_t rd_resp;

	logic cmd_push;
	cmd_word_t cmd_push_data;
	logic [cmd_fifo_address_width:0] cmd_room;
	logic sdo_push;
	sdo_word_t sdo_push_data;
	logic [sdo_fifo_address_width:0] sdo_room;
	logic sdi_pop;
	logic [sdi_data_width-1:0] sdi_head;
	logic [sdi_fifo_address_width:0] sdi_level;

	axi_lite_slave i_axi_lite_slave (
		.awvalid(s_axi_awvalid),
		.awaddr(s_axi_awaddr),
		.awprot(s_axi_awprot),
		.awready(s_axi_awready),
		.wvalid(s_axi_wvalid),
		.wdata(s_axi_wdata),
		.wstrb(s_axi_wstrb),
		.wready(s_axi_wready),
		.bvalid(s_axi_bvalid),
		.bresp(s_axi_bresp),
		.bready(s_axi_bready),
		.arvalid(s_axi_arvalid),
		.araddr(s_axi_araddr),
		.arprot(s_axi_arprot),
		.arready(s_axi_arready),
		.rvalid(s_axi_rvalid),
		.rresp(s_axi_rresp),
		.rdata(s_axi_rdata),
		.rready(s_axi_rready),
		.*
	);

	spi_engine_regs #(
		.cmd_fifo_address_width(cmd_fifo_address_width),
		.sdo_fifo_address_width(sdo_fifo_address_width),
		.sdi_fifo_address_width(sdi_fifo_address_width),
		.sdi_data_width(sdi_data_width),
		.id(id)
	) i_regs (
		.fifo_resetn(spi_resetn),	// Soft reset also holds the core
		.offload_cmd_wr_en(offload0_cmd_wr_en),
		.offload_cmd_wr_data(offload0_cmd_wr_data),
		.offload_sdo_wr_en(offload0_sdo_wr_en),
		.offload_sdo_wr_data(offload0_sdo_wr_data),
		.offload_mem_reset(offload0_mem_reset),
		.offload_enable(offload0_enable),
		.offload_enabled(offload0_enabled),
		.*
	);

	// ******************************************************************
	// Stream FIFOs
	// ******************************************************************

	spi_engine_fifo #(
		.data_width($bits(cmd_word_t)),
		.address_width(cmd_fifo_address_width)
	) i_cmd_fifo (
		.s_axi_aclk(s_axi_aclk),
		.resetn(spi_resetn),
		.in_valid(cmd_push),
		.in_data(cmd_push_data),
		.in_ready(),
		.out_ready(cmd_ready),
		.out_valid(cmd_valid),
		.out_data(cmd_data),
		.level(),
		.room(cmd_room)
	);

	spi_engine_fifo #(
		.data_width($bits(sdo_word_t)),
		.address_width(sdo_fifo_address_width)
	) i_sdo_fifo (
		.s_axi_aclk(s_axi_aclk),
		.resetn(spi_resetn),
		.in_valid(sdo_push),
		.in_data(sdo_push_data),
		.in_ready(),
		.out_ready(sdo_data_ready),
		.out_valid(sdo_data_valid),
		.out_data(sdo_data),
		.level(),
		.room(sdo_room)
	);

	spi_engine_fifo #(
		.data_width(sdi_data_width),
		.address_width(sdi_fifo_address_width)
	) i_sdi_fifo (
		.s_axi_aclk(s_axi_aclk),
		.resetn(spi_resetn),
		.in_valid(sdi_data_valid),
		.in_data(sdi_data),
		.in_ready(sdi_data_ready),
		.out_ready(sdi_pop),
		.out_valid(),	// Empty pop is blocked inside the FIFO
		.out_data(sdi_head),
		.level(sdi_level),
		.room()
	);

endmodule

`default_nettype wire

/* bench/axi_spi_engine_assertions.sv */
`default_nettype none
`timescale 1ns/1ps

module axi_spi_engine_assertions import spi_engine_regs_pkg::*; (
	input logic s_axi_aclk,
	input logic s_axi_aresetn,
	input logic s_axi_awvalid,
	input logic s_axi_awready,
	input logic [31:0] s_axi_awaddr,
	input logic s_axi_bvalid,
	input logic s_axi_bready,
	input logic s_axi_rvalid,
	input logic s_axi_rready,
	input logic cmd_valid,
	input logic cmd_ready,
	input logic sdo_data_valid,
	input logic sdo_data_ready,
	input logic irq
);

	logic mask_written;

	always_ff @(posedge s_axi_aclk) begin
		if (!s_axi_aresetn)
			mask_written <= 1'b0;
		else if (s_axi_awvalid && s_axi_awready && s_axi_awaddr[9:2] == addr_irq_mask)
			mask_written <= 1'b1;
	end

	// ******************************************************************
	// Valid holds until its ready
	// ******************************************************************

	bvalid_held: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
		s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
		else $error("bvalid dropped before bready");

	rvalid_held: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
		s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid)
		else $error("rvalid dropped before rready");

	cmd_valid_held: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
		cmd_valid && !cmd_ready |=> cmd_valid)
		else $error("cmd_valid dropped before cmd_ready");

	sdo_valid_held: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
		sdo_data_valid && !sdo_data_ready |=> sdo_data_valid)
		else $error("sdo_data_valid dropped before sdo_data_ready");

	// Response two cycles after the address handshake
	bvalid_after_write: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
		$past(s_axi_awvalid && s_axi_awready, 2) |-> s_axi_bvalid)
		else $error("no write response after an accepted write");

	irq_quiet: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
		!mask_written |-> !irq)
		else $error("irq raised before the interrupt mask was written");

endmodule

`default_nettype wire

/* bench/axi_spi_engine_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module axi_spi_engine_tb import spi_engine_regs_pkg::*, spi_engine_stream_pkg::*; ();

	localparam int clk_period = 4;
	localparam logic [31:0] tb_id = 32'h5a17_c0de;
	localparam int cmd_depth = 16;
	localparam int sdo_depth = 32;
	localparam int sdi_depth = 32;

	// Output selectors for pin checks
	localparam reg_addr_t pin_spi_resetn = 8'd0;
	localparam reg_addr_t pin_irq = 8'd1;
	localparam reg_addr_t pin_offload_enable = 8'd2;
	localparam reg_addr_t pin_offload_cmd = 8'd3;
	localparam reg_addr_t pin_offload_sdo = 8'd4;
	localparam reg_addr_t pin_mem_reset_count = 8'd5;

	typedef enum logic [2:0] {
		op_write, op_read, op_pin, op_sdi_push, op_sync, op_cmd_pull, op_sdo_pull, op_enabled
	} op_e;

	typedef struct packed {
		op_e op;
		reg_addr_t addr;
		logic [31:0] data;
		logic [31:0] expected;
	} step_t;

	logic s_axi_aclk;
	logic s_axi_aresetn;
	logic s_axi_awvalid;
	logic [31:0] s_axi_awaddr;
	logic s_axi_awready;
	logic [2:0] s_axi_awprot;
	logic s_axi_wvalid;
	logic [31:0] s_axi_wdata;
	logic [3:0] s_axi_wstrb;
	logic s_axi_wready;
	logic s_axi_bvalid;
	logic [1:0] s_axi_bresp;
	logic s_axi_bready;
	logic s_axi_arvalid;
	logic [31:0] s_axi_araddr;
	logic s_axi_arready;
	logic [2:0] s_axi_arprot;
	logic s_axi_rvalid;
	logic s_axi_rready;
	logic [1:0] s_axi_rresp;
	logic [31:0] s_axi_rdata;
	logic irq;
	logic spi_resetn;
	logic cmd_ready;
	logic cmd_valid;
	cmd_word_t cmd_data;
	logic sdo_data_ready;
	logic sdo_data_valid;
	sdo_word_t sdo_data;
	logic sdi_data_ready;
	logic sdi_data_valid;
	logic [7:0] sdi_data;
	logic sync_ready;
	logic sync_valid;
	logic [7:0] sync_data;
	logic offload0_cmd_wr_en;
	cmd_word_t offload0_cmd_wr_data;
	logic offload0_sdo_wr_en;
	sdo_word_t offload0_sdo_wr_data;
	logic offload0_mem_reset;
	logic offload0_enable;
	logic offload0_enabled;

	step_t steps[$];
	cmd_word_t cmd_expected[$];
	sdo_word_t sdo_expected[$];
	logic table_ready = 1'b0;
	cmd_word_t last_offload_cmd = '0;
	sdo_word_t last_offload_sdo = '0;
	int mem_reset_count = 0;

	axi_spi_engine #(
		.cmd_fifo_address_width(4),
		.sdo_fifo_address_width(5),
		.sdi_fifo_address_width(5),
		.sdi_data_width(8),
		.id(tb_id)
	) DUT (.*);

	bind axi_spi_engine axi_spi_engine_assertions protocol_checks (.*);

	initial begin
		s_axi_aclk = 1'b0;
		forever #(clk_period / 2) s_axi_aclk = !s_axi_aclk;
	end

	// Offload memory side samples the strobes mid cycle
	always @(negedge s_axi_aclk) begin
		if (offload0_cmd_wr_en)
			last_offload_cmd <= offload0_cmd_wr_data;
		if (offload0_sdo_wr_en)
			last_offload_sdo <= offload0_sdo_wr_data;
		if (offload0_mem_reset)
			mem_reset_count <= mem_reset_count + 1;
	end

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("mismatch at %0t ns: %s, got 0x%08h, expected 0x%08h",
				$time, what, got, expected);
			$display("Test failed");
			$fatal(1, "value check failed");
		end
	endtask

	// ******************************************************************
	// AXI4-Lite master
	// ******************************************************************

	task automatic axi_write(input reg_addr_t addr, input logic [31:0] data);
		@(posedge s_axi_aclk);
		#1;
		s_axi_awaddr = {22'd0, addr, 2'b00};
		s_axi_wdata = data;
		s_axi_awvalid = 1'b1;
		s_axi_wvalid = 1'b1;
		@(negedge s_axi_aclk);
		while (!s_axi_awready)
			@(negedge s_axi_aclk);
		check_value("wready with awready", 32'(s_axi_wready), 1);
		@(posedge s_axi_aclk);
		#1;
		s_axi_awvalid = 1'b0;
		s_axi_wvalid = 1'b0;
		while (!s_axi_bvalid)
			@(negedge s_axi_aclk);
		check_value("write response code", 32'(s_axi_bresp), 0);
		// Response stalled one cycle by bready
		@(posedge s_axi_aclk);
		#1;
		s_axi_bready = 1'b1;
		@(posedge s_axi_aclk);
		#1;
		s_axi_bready = 1'b0;
	endtask

	task automatic axi_read(input reg_addr_t addr, output logic [31:0] data);
		@(posedge s_axi_aclk);
		#1;
		s_axi_araddr = {22'd0, addr, 2'b00};
		s_axi_arvalid = 1'b1;
		@(negedge s_axi_aclk);
		while (!s_axi_arready)
			@(negedge s_axi_aclk);
		@(posedge s_axi_aclk);
		#1;
		s_axi_arvalid = 1'b0;
		while (!s_axi_rvalid)
			@(negedge s_axi_aclk);
		check_value("read response code", 32'(s_axi_rresp), 0);
		data = s_axi_rdata;
		@(posedge s_axi_aclk);
		#1;
		s_axi_rready = 1'b1;	// Late rready
		@(posedge s_axi_aclk);
		#1;
		s_axi_rready = 1'b0;
	endtask

	// ******************************************************************
	// SPI core model
	// ******************************************************************

	task automatic pull_cmd(input int count);
		int left;
		left = count;
		@(posedge s_axi_aclk);
		#1;
		cmd_ready = 1'b1;
		while (left > 0) begin
			@(negedge s_axi_aclk);
			if (cmd_valid) begin
				check_value("command stream word", 32'(cmd_data), 32'(cmd_expected.pop_front()));
				left--;
			end
			@(posedge s_axi_aclk);
			#1;
		end
		cmd_ready = 1'b0;
	endtask

	task automatic pull_sdo(input int count);
		int left;
		left = count;
		@(posedge s_axi_aclk);
		#1;
		sdo_data_ready = 1'b1;
		while (left > 0) begin
			@(negedge s_axi_aclk);
			if (sdo_data_valid) begin
				check_value("SDO stream byte", 32'(sdo_data), 32'(sdo_expected.pop_front()));
				left--;
			end
			@(posedge s_axi_aclk);
			#1;
		end
		sdo_data_ready = 1'b0;
	endtask

	task automatic push_sdi(input logic [7:0] word);
		@(posedge s_axi_aclk);
		#1;
		sdi_data_valid = 1'b1;
		sdi_data = word;
		@(negedge s_axi_aclk);
		while (!sdi_data_ready)
			@(negedge s_axi_aclk);
		@(posedge s_axi_aclk);
		#1;
		sdi_data_valid = 1'b0;
	endtask

	task automatic pulse_sync(input logic [7:0] sync_id);
		@(posedge s_axi_aclk);
		#1;
		sync_valid = 1'b1;
		sync_data = sync_id;
		@(negedge s_axi_aclk);
		check_value("sync_ready", 32'(sync_ready), 1);
		@(posedge s_axi_aclk);
		#1;
		sync_valid = 1'b0;
	endtask

	function automatic logic [31:0] pin_value(input reg_addr_t sel);
		case (sel)
		pin_spi_resetn: return 32'(spi_resetn);
		pin_irq: return 32'(irq);
		pin_offload_enable: return 32'(offload0_enable);
		pin_offload_cmd: return 32'(last_offload_cmd);
		pin_offload_sdo: return 32'(last_offload_sdo);
		pin_mem_reset_count: return 32'(mem_reset_count);
		default: return '0;
		endcase
	endfunction

	// Watermark is three quarters of the depth
	function automatic logic [31:0] expected_source(input int cmd_room, input int sdo_room,
			input int sdi_level, input bit sync);
		logic [31:0] src;
		src = '0;
		src[irq_cmd_almost_empty] = cmd_room * 4 >= cmd_depth * 3;
		src[irq_sdo_almost_empty] = sdo_room * 4 >= sdo_depth * 3;
		src[irq_sdi_almost_full] = sdi_level * 4 >= sdi_depth * 3;
		src[irq_sync] = sync;
		return src;
	endfunction

	// ******************************************************************
	// Stimulus table
	// ******************************************************************

	function automatic void add_step(input op_e op, input reg_addr_t addr,
			input logic [31:0] data, input logic [31:0] expected);
		steps.push_back('{op, addr, data, expected});
	endfunction

	task automatic build_table();
		logic [31:0] w;
		logic [31:0] sdi_words[3];
		logic [31:0] src;
		logic [7:0] sid;
		w = $urandom();
		add_step(op_read, addr_version, 0, 32'h0001_0071);
		add_step(op_read, addr_id, 0, tb_id);
		add_step(op_write, addr_scratch, w, 0);
		add_step(op_read, addr_scratch, 0, w);
		add_step(op_read, addr_reset, 0, 1);
		add_step(op_pin, pin_spi_resetn, 0, 0);

		// Command FIFO held back by the core
		add_step(op_write, addr_reset, 0, 0);
		add_step(op_pin, pin_spi_resetn, 0, 1);
		add_step(op_read, addr_cmd_room, 0, cmd_depth);
		for (int i = 1; i <= 5; i++) begin
			add_step(op_write, addr_cmd_fifo, $urandom(), 0);
			add_step(op_read, addr_cmd_room, 0, cmd_depth - i);
		end
		add_step(op_cmd_pull, 0, 3, 0);
		add_step(op_read, addr_cmd_room, 0, cmd_depth - 2);
		add_step(op_cmd_pull, 0, 2, 0);
		add_step(op_read, addr_cmd_room, 0, cmd_depth);

		for (int i = 0; i < 6; i++)
			add_step(op_write, addr_sdo_fifo, $urandom(), 0);
		add_step(op_read, addr_sdo_room, 0, sdo_depth - 6);
		add_step(op_sdo_pull, 0, 4, 0);
		for (int i = 0; i < 3; i++)
			add_step(op_write, addr_sdo_fifo, $urandom(), 0);
		add_step(op_read, addr_sdo_room, 0, sdo_depth - 5);
		add_step(op_sdo_pull, 0, 5, 0);
		add_step(op_read, addr_sdo_room, 0, sdo_depth);

		// SDI words are peeked and then popped
		add_step(op_read, addr_sdi_level, 0, 0);
		foreach (sdi_words[i]) begin
			sdi_words[i] = $urandom() & 32'hff;
			add_step(op_sdi_push, 0, sdi_words[i], 0);
		end
		add_step(op_read, addr_sdi_level, 0, 3);
		add_step(op_read, addr_sdi_peek, 0, sdi_words[0]);
		add_step(op_read, addr_sdi_level, 0, 3);
		foreach (sdi_words[i]) begin
			add_step(op_read, addr_sdi_fifo, 0, sdi_words[i]);
			add_step(op_read, addr_sdi_level, 0, 2 - i);
		end

		// ******************************************************************
		// Interrupt and sync
		// ******************************************************************

		add_step(op_read, addr_irq_source, 0, expected_source(cmd_depth, sdo_depth, 0, 0));
		add_step(op_read, addr_irq_pending, 0, 0);
		add_step(op_write, addr_irq_mask, 32'h4, 0);
		for (int i = 1; i <= 24; i++) begin
			add_step(op_sdi_push, 0, $urandom() & 32'hff, 0);
			if (i >= 23) begin
				src = expected_source(cmd_depth, sdo_depth, i, 0);
				add_step(op_read, addr_irq_source, 0, src);
				add_step(op_read, addr_irq_pending, 0, src & 32'h4);
				add_step(op_pin, pin_irq, 0, 32'(|(src & 32'h4)));
			end
		end
		add_step(op_write, addr_reset, 1, 0);	// Flush through soft reset
		add_step(op_write, addr_reset, 0, 0);
		add_step(op_read, addr_sdi_level, 0, 0);
		add_step(op_write, addr_irq_mask, 32'h8, 0);
		add_step(op_pin, pin_irq, 0, 0);
		sid = 8'($urandom());
		add_step(op_sync, 0, 32'(sid), 0);
		add_step(op_read, addr_sync_id, 0, 32'(sid));
		add_step(op_read, addr_irq_source, 0, expected_source(cmd_depth, sdo_depth, 0, 1));
		add_step(op_read, addr_irq_pending, 0, 32'h8);
		add_step(op_pin, pin_irq, 0, 1);
		add_step(op_write, addr_irq_pending, 32'h8, 0);
		add_step(op_read, addr_irq_pending, 0, 0);
		add_step(op_pin, pin_irq, 0, 0);
		add_step(op_read, addr_sync_id, 0, 32'(sid));

		// Offload memory strobes
		w = $urandom();
		add_step(op_write, addr_offload_cmd, w, 0);
		add_step(op_pin, pin_offload_cmd, 0, w & 32'hffff);
		w = $urandom();
		add_step(op_write, addr_offload_sdo, w, 0);
		add_step(op_pin, pin_offload_sdo, 0, w & 32'hff);
		add_step(op_write, addr_offload_enable, 1, 0);
		add_step(op_read, addr_offload_enable, 0, 1);
		add_step(op_pin, pin_offload_enable, 0, 1);
		add_step(op_read, addr_offload_enabled, 0, 0);
		add_step(op_enabled, 0, 1, 0);
		add_step(op_read, addr_offload_enabled, 0, 1);
		add_step(op_write, addr_offload_mem_reset, 1, 0);
		add_step(op_pin, pin_mem_reset_count, 0, 1);
	endtask

	task automatic apply_step(input step_t s);
		logic [31:0] got;
		case (s.op)
		op_write: begin
			if (s.addr == addr_cmd_fifo)
				cmd_expected.push_back(s.data[15:0]);
			if (s.addr == addr_sdo_fifo)
				sdo_expected.push_back(s.data[7:0]);
			axi_write(s.addr, s.data);
		end
		op_read: begin
			axi_read(s.addr, got);
			check_value($sformatf("read of register 0x%02h", s.addr), got, s.expected);
		end
		op_pin: begin
			repeat (2) @(posedge s_axi_aclk);	// irq lags pending by a cycle
			@(negedge s_axi_aclk);
			check_value($sformatf("output selector %0d", s.addr), pin_value(s.addr),
				s.expected);
		end
		op_sdi_push: push_sdi(s.data[7:0]);
		op_sync: pulse_sync(s.data[7:0]);
		op_cmd_pull: pull_cmd(int'(s.data));
		op_sdo_pull: pull_sdo(int'(s.data));
		op_enabled: begin
			@(posedge s_axi_aclk);
			#1;
			offload0_enabled = s.data[0];
		end
		default: ;
		endcase
	endtask

	initial begin
		int limit_cycles;
		wait (table_ready);
		limit_cycles = steps.size() * 40 + 500;
		repeat (limit_cycles) @(posedge s_axi_aclk);
		$display("Timeout: the stimulus table did not complete in time");
		$display("Test failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		void'($urandom(81642));
		s_axi_aresetn = 1'b0;
		s_axi_awvalid = 1'b0;
		s_axi_awaddr = '0;
		s_axi_awprot = '0;
		s_axi_wvalid = 1'b0;
		s_axi_wdata = '0;
		s_axi_wstrb = 4'hf;
		s_axi_bready = 1'b0;
		s_axi_arvalid = 1'b0;
		s_axi_araddr = '0;
		s_axi_arprot = '0;
		s_axi_rready = 1'b0;
		cmd_ready = 1'b0;
		sdo_data_ready = 1'b0;
		sdi_data_valid = 1'b0;
		sdi_data = '0;
		sync_valid = 1'b0;
		sync_data = '0;
		offload0_enabled = 1'b0;
		build_table();
		table_ready = 1'b1;
		repeat (16) @(posedge s_axi_aclk);
		#1;
		s_axi_aresetn = 1'b1;
		foreach (steps[i])
			apply_step(steps[i]);
		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
source/spi_engine_regs_pkg.sv
source/spi_engine_stream_pkg.sv
source/axi_lite_slave.sv
source/spi_engine_fifo.sv
source/spi_engine_regs.sv
source/axi_spi_engine.sv
bench/axi_spi_engine_assertions.sv
bench/axi_spi_engine_tb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator and run; the exit status is the simulator's own
verilator --binary --assert -Wno-fatal --top-module axi_spi_engine_tb -f files.f -o sim \
	&& ./obj_dir/sim \
	|| exit 1
